// File: flist.f
+incdir+include
source/sbus_pkg.sv
source/sbus_frame_rx.sv
source/sbus_word_rx.sv
source/sbus_seq.sv
source/sbus_mem.sv
source/sbus_word_tx.sv
source/sbus_target.sv
sim/tb_sbus_target.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_sbus_target
FILE_LIST  := flist.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/tb_sbus_target.sv
`timescale 1ns/100ps
`default_nettype none
`include "sbus_settings.svh"

module tb_sbus_target;

    localparam int DATA_W     = `SBUS_DATA_WIDTH;
    localparam int ADDR_W     = $clog2(`SBUS_ADDR_DEPTH);
    localparam int ID_W       = `SBUS_ID_WIDTH;
    localparam int START_W    = $bits(`SBUS_START_CODE);
    localparam int FRAME_W    = START_W + ID_W + 2 + ADDR_W;
    localparam int WAIT_LIMIT = 400;
    localparam int BURST_LEN  = 6;

    localparam logic [START_W-1:0] START_CODE = `SBUS_START_CODE;
    localparam logic [START_W-1:0] BAD_START  = START_CODE ^ START_W'(1);
    localparam logic [ID_W-1:0]    OWN_ID     = 1;
    localparam logic [ID_W-1:0]    FOREIGN_ID = OWN_ID + 1'b1;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    wire  rD;
    wire  ready;

    logic [31:0]       rng_state;
    // words the target should hold, keyed by address
    logic [DATA_W-1:0] model [logic [ADDR_W-1:0]];

    sbus_target #(
        .TARGET_ID (OWN_ID)
    ) u_dut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // reference for a read, unwritten words come back unknown
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        if (model.exists(addr)) begin
            return model[addr];
        end
        return 'x;
    endfunction

    task automatic stop_on_error();
        $display("sim failed");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    // returns on the first falling edge that sees ready at the level
    task automatic wait_ready(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (ready !== level) begin
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout while waiting for ready to become %b", level);
                stop_on_error();
            end
            @(negedge clk);
        end
    endtask

    // the receiver's word strobe inside the DUT marks a finished write word
    task automatic wait_word_done();
        int n;
        n = 0;
        @(negedge clk);
        while (u_dut.word_done !== 1'b1) begin
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout while waiting for a write word to complete");
                stop_on_error();
            end
            @(negedge clk);
        end
    endtask

    task automatic send_frame(input logic [START_W-1:0] start, input logic [ID_W-1:0] id,
                              input logic rw, input logic burst,
                              input logic [ADDR_W-1:0] addr);
        logic [FRAME_W-1:0] frame;
        frame = {start, id, rw, burst, addr};
        for (int i = FRAME_W - 1; i >= 0; i--) begin
            @(posedge clk);
            control <= frame[i];
        end
        @(posedge clk);
        control <= 1'b0;
        // one more edge so the sequencer has taken the frame
        @(posedge clk);
    endtask

    // msb first with random idle cycles between bits
    task automatic drive_word(input logic [DATA_W-1:0] data, input logic final_word);
        int gap;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            gap = int'(next_random() % 32'd3);
            repeat (gap) begin
                @(posedge clk);
                valid <= 1'b0;
            end
            @(posedge clk);
            valid <= 1'b1;
            wD    <= data[i];
            last  <= final_word && (i == 0);
        end
        @(posedge clk);
        valid <= 1'b0;
        last  <= 1'b0;
    endtask

    task automatic write_words(input logic [ADDR_W-1:0] addr, input int count,
                               input logic burst);
        logic [DATA_W-1:0] data;
        logic [ADDR_W-1:0] a;
        send_frame(START_CODE, OWN_ID, 1'b1, burst, addr);
        for (int w = 0; w < count; w++) begin
            a    = addr + ADDR_W'(w);
            data = DATA_W'(next_random());
            drive_word(data, burst && (w == count - 1));
            wait_word_done();
            model[a] = data;
        end
    endtask

    // each word starts where ready rises again after a low gap
    task automatic read_words(input logic [ADDR_W-1:0] addr, input int count,
                              input logic burst);
        logic [DATA_W-1:0] got;
        logic [ADDR_W-1:0] a;
        send_frame(START_CODE, OWN_ID, 1'b0, burst, addr);
        for (int w = 0; w < count; w++) begin
            a = addr + ADDR_W'(w);
            wait_ready(1'b0);
            wait_ready(1'b1);
            for (int i = DATA_W - 1; i >= 0; i--) begin
                check_value("ready", DATA_W'(ready), DATA_W'(1'b1));
                got[i] = rD;
                if (i > 0) begin
                    @(posedge clk);
                    // one-cycle last pulse in the middle of the final word
                    last <= burst && (w == count - 1) && (i == 16);
                    @(negedge clk);
                end
            end
            check_value("rD", got, expected_word(a));
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("ready", DATA_W'(ready), DATA_W'(1'b1));
            check_value("rD", DATA_W'(rD), '0);
        end
    endtask

    // data after a frame the target must ignore
    task automatic send_dropped_write(input logic [START_W-1:0] start,
                                      input logic [ID_W-1:0] id,
                                      input logic [ADDR_W-1:0] addr);
        send_frame(start, id, 1'b1, 1'b0, addr);
        wait_ready(1'b1);
        drive_word(DATA_W'(next_random()), 1'b0);
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] base;
        clk       = 1'b0;
        rstN      = 1'b0;
        control   = 1'b0;
        wD        = 1'b0;
        valid     = 1'b0;
        last      = 1'b0;
        rng_state = 32'h2d59;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;

        @(negedge clk);
        check_value("ready", DATA_W'(ready), DATA_W'(1'b1));
        check_value("rD", DATA_W'(rD), '0);

        // single write then single read
        addr = ADDR_W'(next_random());
        write_words(addr, 1, 1'b0);
        read_words(addr, 1, 1'b0);

        // burst write, read back word by word
        base = ADDR_W'(next_random());
        write_words(base, BURST_LEN, 1'b1);
        for (int w = 0; w < BURST_LEN; w++) begin
            read_words(base + ADDR_W'(w), 1, 1'b0);
        end

        read_words(base, BURST_LEN, 1'b1);
        check_idle(2 * DATA_W);

        // foreign id, then a bad start code
        send_dropped_write(START_CODE, FOREIGN_ID, base);
        read_words(base, 1, 1'b0);
        send_dropped_write(BAD_START, OWN_ID, base);
        read_words(base, 1, 1'b0);
        check_idle(4);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/sbus_target.sv
`timescale 1ns/100ps
`default_nettype none

module sbus_target #(
    parameter sbus_pkg::target_id_t TARGET_ID = 1
) (
    input  wire  clk,
    input  wire  rstN,
    input  wire  control,
    input  wire  wD,
    input  wire  valid,
    input  wire  last,
    output logic rD,
    output logic ready
);

    logic            frame_busy;
    logic            frame_hit;
    logic            is_write;
    logic            is_burst;
    sbus_pkg::addr_t start_addr;
    sbus_pkg::data_t rx_word;
    logic            word_done;
    logic            word_last;
    logic            rx_enable;
    logic            mem_wr_en;
    sbus_pkg::addr_t mem_addr;
    sbus_pkg::data_t rd_data;
    logic            tx_load;
    logic            tx_done;

    // input side
    sbus_frame_rx #(
        .TARGET_ID (TARGET_ID)
    ) u_frame_rx (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .frame_busy (frame_busy),
        .frame_hit  (frame_hit),
        .is_write   (is_write),
        .is_burst   (is_burst),
        .start_addr (start_addr)
    );

    sbus_word_rx u_word_rx (
        .clk       (clk),
        .rstN      (rstN),
        .rx_enable (rx_enable),
        .valid     (valid),
        .wD        (wD),
        .last      (last),
        .word      (rx_word),
        .word_done (word_done),
        .word_last (word_last)
    );

    sbus_seq u_seq (
        .clk        (clk),
        .rstN       (rstN),
        .frame_busy (frame_busy),
        .frame_hit  (frame_hit),
        .is_write   (is_write),
        .is_burst   (is_burst),
        .start_addr (start_addr),
        .word_done  (word_done),
        .word_last  (word_last),
        .tx_done    (tx_done),
        .last       (last),
        .rx_enable  (rx_enable),
        .mem_wr_en  (mem_wr_en),
        .mem_addr   (mem_addr),
        .tx_load    (tx_load),
        .ready      (ready)
    );

    sbus_mem u_mem (
        .clk       (clk),
        .mem_wr_en (mem_wr_en),
        .mem_addr  (mem_addr),
        .wr_data   (rx_word),
        .rd_data   (rd_data)
    );

    // output side
    sbus_word_tx u_word_tx (
        .clk       (clk),
        .rstN      (rstN),
        .tx_load   (tx_load),
        .load_word (rd_data),
        .rD        (rD),
        .tx_done   (tx_done)
    );

endmodule

`default_nettype wire

// File: source/sbus_word_tx.sv
`timescale 1ns/100ps
`default_nettype none
`include "sbus_settings.svh"

module sbus_word_tx (
    input  wire             clk,
    input  wire             rstN,
    input  wire             tx_load,
    input  wire             sbus_pkg::data_t load_word,
    output logic            rD,
    output logic            tx_done
);
    import sbus_pkg::*;

    data_t      shift_q;
    bit_count_t bits_left;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bits_left <= '0;
        end else if (tx_load) begin
            bits_left <= bit_count_t'(`SBUS_DATA_WIDTH);
        end else if (bits_left != '0) begin
            bits_left <= bits_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_load) begin
            shift_q <= load_word;
        end else if (bits_left != '0) begin
            shift_q <= shift_q << 1;
        end
    end

    // msb first, line held low between words
    assign rD      = (bits_left != '0) && shift_q[`SBUS_DATA_WIDTH-1];
    assign tx_done = (bits_left == bit_count_t'(1));

endmodule

`default_nettype wire

// File: source/sbus_mem.sv
`timescale 1ns/100ps
`default_nettype none
`include "sbus_settings.svh"

module sbus_mem (
    input  wire             clk,
    input  wire             mem_wr_en,
    input  wire             sbus_pkg::addr_t mem_addr,
    input  wire             sbus_pkg::data_t wr_data,
    output sbus_pkg::data_t rd_data
);

    sbus_pkg::data_t mem_q [`SBUS_ADDR_DEPTH];

    // read every cycle, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem_q[mem_addr] <= wr_data;
        end
        rd_data <= mem_q[mem_addr];
    end

endmodule

`default_nettype wire

// File: source/sbus_seq.sv
`timescale 1ns/100ps
`default_nettype none

module sbus_seq (
    input  wire             clk,
    input  wire             rstN,
    input  wire             frame_busy,
    input  wire             frame_hit,
    input  wire             is_write,
    input  wire             is_burst,
    input  wire             sbus_pkg::addr_t start_addr,
    input  wire             word_done,
    input  wire             word_last,
    input  wire             tx_done,
    input  wire             last,
    output logic            rx_enable,
    output logic            mem_wr_en,
    output sbus_pkg::addr_t mem_addr,
    output logic            tx_load,
    output logic            ready
);
    import sbus_pkg::*;

    seq_state_t state;
    addr_t      addr_q;
    logic       burst_q;
    logic       last_q;
    logic       rd_end;

    // last seen at any point of the current read word ends the burst
    assign rd_end = !burst_q || last_q || last;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= IDLE;
            addr_q  <= '0;
            burst_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame_hit) begin
                        addr_q  <= start_addr;
                        burst_q <= is_burst;
                        last_q  <= 1'b0;
                        state   <= is_write ? WR_DATA : RD_FETCH;
                    end
                end
                WR_DATA: begin
                    if (word_done) begin
                        addr_q <= addr_q + 1'b1;
                        if (!burst_q || word_last) begin
                            state <= IDLE;
                        end
                    end
                end
                // address goes to the memory here
                RD_FETCH: begin
                    state <= RD_LOAD;
                end
                RD_LOAD: begin
                    state <= RD_SHIFT;
                end
                RD_SHIFT: begin
                    if (last) begin
                        last_q <= 1'b1;
                    end
                    if (tx_done) begin
                        if (rd_end) begin
                            state <= IDLE;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                            state  <= RD_FETCH;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign rx_enable = (state == WR_DATA);
    assign mem_wr_en = (state == WR_DATA) && word_done;
    assign mem_addr  = addr_q;
    assign tx_load   = (state == RD_LOAD);

    // low while a frame comes in and in the gap between read words
    assign ready = ((state == IDLE) && !frame_busy)
                || (state == WR_DATA)
                || (state == RD_SHIFT);

endmodule

`default_nettype wire

// File: source/sbus_word_rx.sv
`timescale 1ns/100ps
`default_nettype none
`include "sbus_settings.svh"

module sbus_word_rx (
    input  wire             clk,
    input  wire             rstN,
    input  wire             rx_enable,
    input  wire             valid,
    input  wire             wD,
    input  wire             last,
    output sbus_pkg::data_t word,
    output logic            word_done,
    output logic            word_last
);
    import sbus_pkg::*;

    bit_count_t bit_cnt;
    logic       final_bit;

    assign final_bit = valid && (bit_cnt == bit_count_t'(`SBUS_DATA_WIDTH - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt   <= '0;
            word_done <= 1'b0;
            word_last <= 1'b0;
        end else begin
            word_done <= 1'b0;
            if (!rx_enable) begin
                bit_cnt <= '0;
            end else if (final_bit) begin
                bit_cnt   <= '0;
                word_done <= 1'b1;
                // last counts only when it comes with the final bit
                word_last <= last;
            end else if (valid) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // msb arrives first
    always_ff @(posedge clk) begin
        if (rx_enable && valid) begin
            word <= {word[`SBUS_DATA_WIDTH-2:0], wD};
        end
    end

endmodule

`default_nettype wire

// File: source/sbus_frame_rx.sv
`timescale 1ns/100ps
`default_nettype none
`include "sbus_settings.svh"

module sbus_frame_rx #(
    parameter sbus_pkg::target_id_t TARGET_ID = 1
) (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire                  control,
    output logic                 frame_busy,
    output logic                 frame_hit,
    output logic                 is_write,
    output logic                 is_burst,
    output sbus_pkg::addr_t      start_addr
);
    import sbus_pkg::*;

    // field positions inside the collected frame
    localparam int BURST_BIT = ADDR_WIDTH;
    localparam int RW_BIT    = ADDR_WIDTH + 1;
    localparam int ID_LSB    = ADDR_WIDTH + 2;

    frame_t     shift_q;
    frame_t     frame_next;
    bit_count_t bit_cnt;
    logic       frame_done;
    logic       last_bit;

    assign frame_next = {shift_q[FRAME_WIDTH-2:0], control};
    assign last_bit   = frame_busy && (bit_cnt == bit_count_t'(FRAME_WIDTH - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            frame_busy <= 1'b0;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= last_bit;
            if (!frame_busy) begin
                // a high control bit while idle is the first start bit
                if (control) begin
                    frame_busy <= 1'b1;
                    bit_cnt    <= bit_count_t'(1);
                end
            end else if (last_bit) begin
                frame_busy <= 1'b0;
                bit_cnt    <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // the frame stays put between frames, so fields hold through frame_done
    always_ff @(posedge clk) begin
        if (frame_busy || control) begin
            shift_q <= frame_next;
        end
    end

    assign is_write   = shift_q[RW_BIT];
    assign is_burst   = shift_q[BURST_BIT];
    assign start_addr = shift_q[ADDR_WIDTH-1:0];

    // foreign id or bad start code gives a silent drop
    assign frame_hit = frame_done
                    && (shift_q[FRAME_WIDTH-1 -: START_WIDTH] == `SBUS_START_CODE)
                    && (shift_q[ID_LSB +: `SBUS_ID_WIDTH] == TARGET_ID);

endmodule

`default_nettype wire

// File: source/sbus_pkg.sv
`default_nettype none
`include "sbus_settings.svh"

package sbus_pkg;

    localparam int ADDR_WIDTH  = $clog2(`SBUS_ADDR_DEPTH);
    localparam int START_WIDTH = $bits(`SBUS_START_CODE);
    // start | id | rw | burst | address
    localparam int FRAME_WIDTH = START_WIDTH + `SBUS_ID_WIDTH + 2 + ADDR_WIDTH;

    typedef logic [`SBUS_DATA_WIDTH-1:0]       data_t;
    typedef logic [ADDR_WIDTH-1:0]             addr_t;
    typedef logic [`SBUS_ID_WIDTH-1:0]         target_id_t;
    typedef logic [FRAME_WIDTH-1:0]            frame_t;
    typedef logic [$clog2(`SBUS_DATA_WIDTH):0] bit_count_t;

    typedef enum logic [2:0] {
        IDLE,
        WR_DATA,
        RD_FETCH,
        RD_LOAD,
        RD_SHIFT
    } seq_state_t;

endpackage

`default_nettype wire

// File: include/sbus_settings.svh
`ifndef SBUS_SETTINGS_SVH
`define SBUS_SETTINGS_SVH

// bits carried by one data word on wD and rD
`define SBUS_DATA_WIDTH 32

// words held by the target memory
`define SBUS_ADDR_DEPTH 256

// width of the target id field in the control frame
`define SBUS_ID_WIDTH 2

// leading code of every control frame
`define SBUS_START_CODE 3'b111

`endif
